//--- build.f
+incdir+include
hdl/smpc_pkg.sv
hdl/smpc_oreg_ram.sv
hdl/smpc_host_regs.sv
hdl/smpc_rtc.sv
hdl/smpc_command.sv
hdl/smpc_top.sv
tb/smpc_assertions.sv
tb/smpc_tb.sv

//--- tb/smpc_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "smpc_defines.svh"

module smpc_tb;

	import smpc_pkg::*;

	logic         CLK = 1'b0;
	logic         RST_N;
	logic         ce;
	logic         mres_n;
	logic [5:0]   addr;
	smpc_byte_t   din;
	logic         cs_n;
	logic         rw_n;
	logic [3:0]   area;
	smpc_byte_t   dout;
	reset_lines_t resets;
	logic         mirq_n;

	logic [15:0]  stim_lfsr = 16'd51273;
	logic [15:0]  ce_lfsr = 16'd51273;
	int           ce_seen = 0; // ce cycles handed to the DUT
	int           irq_pulses = 0;
	int           errors = 0;
	int           timeouts = 0;
	int           ce_mark;
	reset_lines_t exp_resets;
	logic         exp_resd;
	rtc_time_t    set_time;
	smpc_byte_t   rd;
	smpc_byte_t   wdata;
	smpc_byte_t   code;
	smpc_byte_t   line_cmds [8] = '{`SMPC_CMD_MSHON, `SMPC_CMD_SSHON, `SMPC_CMD_SSHOFF,
		`SMPC_CMD_SNDON, `SMPC_CMD_SNDOFF, `SMPC_CMD_CDON, `SMPC_CMD_CDOFF, `SMPC_CMD_NMIREQ};

	smpc_top smpc_top_i (.*);

	bind smpc_command smpc_assertions assertions_i (
		.CLK(CLK), .RST_N(RST_N), .state(state), .oreg_wr(oreg_wr), .sf_clear(sf_clear)
	);

	always #2 CLK = ~CLK;

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], stim_lfsr[0]};
			stim_lfsr = lfsr_next(stim_lfsr);
		end
		return v;
	endfunction

	// About three ce cycles in four
	always @(posedge CLK) begin : ce_drive
		logic b0;
		logic b1;
		b0 = ce_lfsr[0];
		ce_lfsr = lfsr_next(ce_lfsr);
		b1 = ce_lfsr[0];
		ce_lfsr = lfsr_next(ce_lfsr);
		ce <= b0 | b1;
		if (b0 | b1) ce_seen <= ce_seen + 1;
	end

	// Interrupt pulses seen on mirq_n
	always @(negedge mirq_n) begin : irq_count
		if (RST_N === 1'b1) irq_pulses <= irq_pulses + 1;
	end

	function automatic logic [5:0] oreg_addr(input int i);
		return 6'(`SMPC_A_OREG_FIRST + i);
	endfunction

	function automatic int bcd_to_int(input smpc_byte_t b);
		return b[7:4] * 10 + b[3:0];
	endfunction

	function automatic smpc_byte_t int_to_bcd(input int v);
		return {4'(v / 10), 4'(v % 10)};
	endfunction

	function automatic int month_days(input int m);
		if (m == 2) return 28;
		if (m == 4 || m == 6 || m == 9 || m == 11) return 30;
		return 31;
	endfunction

	// Weekday is not advanced by the calendar
	function automatic rtc_time_t next_second(input rtc_time_t t);
		int s;
		int mi;
		int h;
		int d;
		int mo;
		int y;
		s = bcd_to_int(t.sec) + 1;
		mi = bcd_to_int(t.min);
		h = bcd_to_int(t.hour);
		d = bcd_to_int(t.days);
		mo = t.month;
		y = bcd_to_int(t.year[15:8]) * 100 + bcd_to_int(t.year[7:0]);
		if (s == 60) begin
			s = 0;
			mi++;
		end
		if (mi == 60) begin
			mi = 0;
			h++;
		end
		if (h == 24) begin
			h = 0;
			d++;
		end
		if (d > month_days(mo)) begin
			d = 1;
			mo++;
		end
		if (mo == 13) begin
			mo = 1;
			y = (y + 1) % 10000;
		end
		t.sec = int_to_bcd(s);
		t.min = int_to_bcd(mi);
		t.hour = int_to_bcd(h);
		t.days = int_to_bcd(d);
		t.month = 4'(mo);
		t.year = {int_to_bcd(y / 100), int_to_bcd(y % 100)};
		return t;
	endfunction

	function automatic rtc_time_t random_time();
		rtc_time_t t;
		int mo;
		mo = 1 + rand_bits(4) % 12;
		t.year = {int_to_bcd(19 + rand_bits(1)), int_to_bcd(rand_bits(7) % 100)};
		t.weekday = 4'(rand_bits(3) % 7);
		t.month = 4'(mo);
		t.days = int_to_bcd(1 + rand_bits(5) % month_days(mo));
		t.hour = int_to_bcd(rand_bits(5) % 24);
		t.min = int_to_bcd(rand_bits(6) % 60);
		t.sec = int_to_bcd(rand_bits(6) % 60);
		return t;
	endfunction

	task automatic check_byte(input string name, input smpc_byte_t got, input smpc_byte_t want);
		if (got !== want) begin
			errors++;
			$display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, want);
		end
	endtask

	task automatic check_resets(input reset_lines_t got, input reset_lines_t want);
		if (got !== want) begin
			errors++;
			$display("[ERROR] %0t resets: got %b, expected %b", $time, got, want);
		end
	endtask

	// Returns at the first clock edge that sees ce high
	task automatic wait_ce_edge(input string what);
		int n;
		n = 0;
		do begin
			@(posedge CLK);
			n++;
		end while (!ce && n < 64);
		if (!ce) begin
			timeouts++;
			$display("Timeout: no ce cycle seen during %s", what);
		end
	endtask

	task automatic wait_ce_count(input int n);
		int start;
		int cycles;
		start = ce_seen;
		cycles = 0;
		while (ce_seen - start < n && cycles < 8 * n) begin
			@(posedge CLK);
			cycles++;
		end
		if (ce_seen - start < n) begin
			timeouts++;
			$display("Timeout: only %0d of %0d ce cycles seen", ce_seen - start, n);
		end
	endtask

	task automatic host_write(input logic [5:0] a, input smpc_byte_t d);
		@(posedge CLK);
		addr <= a;
		din  <= d;
		cs_n <= 1'b0;
		rw_n <= 1'b0;
		@(posedge CLK); // Write edge taken here
		wait_ce_edge("host write");
		cs_n <= 1'b1;
		rw_n <= 1'b1;
	endtask

	task automatic host_read(input logic [5:0] a, output smpc_byte_t d);
		@(posedge CLK);
		addr <= a;
		rw_n <= 1'b1;
		cs_n <= 1'b1;
		@(posedge CLK);
		cs_n <= 1'b0;
		@(posedge CLK);
		@(negedge CLK);
		d = dout;
		@(posedge CLK);
		cs_n <= 1'b1;
	endtask

	task automatic pulse_mres();
		@(posedge CLK);
		mres_n <= 1'b0;
		wait_ce_edge("MRES pulse");
		wait_ce_edge("MRES pulse");
		mres_n <= 1'b1;
		@(negedge CLK);
	endtask

	// Expected effect of a command on the lines and RESD
	task automatic apply_line_command(input smpc_byte_t c);
		case (c)
			`SMPC_CMD_MSHON:   {exp_resets.mshres_n, exp_resets.mshnmi_n} = 2'b11;
			`SMPC_CMD_SSHON:   {exp_resets.sshres_n, exp_resets.sshnmi_n} = 2'b11;
			`SMPC_CMD_SSHOFF:  {exp_resets.sshres_n, exp_resets.sshnmi_n} = 2'b01;
			`SMPC_CMD_SNDON:   exp_resets.sndres_n = 1'b1;
			`SMPC_CMD_SNDOFF:  exp_resets.sndres_n = 1'b0;
			`SMPC_CMD_CDON:    exp_resets.cdres_n = 1'b1;
			`SMPC_CMD_CDOFF:   exp_resets.cdres_n = 1'b0;
			`SMPC_CMD_NMIREQ:  exp_resets.mshnmi_n = 1'b1; // NMI released again in end
			`SMPC_CMD_RESENAB: exp_resd = 1'b0;
			`SMPC_CMD_RESDISA: exp_resd = 1'b1;
			default: ;
		endcase
	endtask

	task automatic run_command(input smpc_byte_t c);
		smpc_byte_t sf_byte;
		int n;
		host_write(`SMPC_A_SF, 8'h01);
		host_write(`SMPC_A_COMREG, c);
		n = 0;
		do begin
			host_read(`SMPC_A_SF, sf_byte);
			n++;
		end while (sf_byte[0] && n < 200);
		if (sf_byte[0]) begin
			timeouts++;
			$display("Timeout: SF still set after command %h", c);
		end
		host_read(oreg_addr(`SMPC_OREG_CMD_INDEX), rd);
		check_byte("OREG31", rd, c);
		@(negedge CLK);
		check_resets(resets, exp_resets);
	endtask

	task automatic load_time(input rtc_time_t t);
		host_write(`SMPC_A_IREG0, t.year[15:8]);
		host_write(`SMPC_A_IREG0 + 6'd1, t.year[7:0]);
		host_write(`SMPC_A_IREG0 + 6'd2, {t.weekday, t.month});
		host_write(`SMPC_A_IREG0 + 6'd3, t.days);
		host_write(`SMPC_A_IREG0 + 6'd4, t.hour);
		host_write(`SMPC_A_IREG0 + 6'd5, t.min);
		host_write(`SMPC_A_IREG0 + 6'd6, t.sec);
		run_command(`SMPC_CMD_SETTIME);
	endtask

	// Time may have stepped once more than the counted ce cycles show
	task automatic check_intback(input rtc_time_t base, input int ce_start);
		rtc_time_t  lo;
		rtc_time_t  hi;
		rtc_time_t  got;
		smpc_byte_t st [12];
		smpc_byte_t want [12];
		int         ticks;
		int         irq_start;
		ticks = (ce_seen - ce_start) / `SMPC_RTC_TICK;
		lo = base;
		for (int i = 0; i < ticks; i++) begin
			lo = next_second(lo);
		end
		hi = next_second(lo);
		host_write(`SMPC_A_IREG0, {4'h0, 4'(1 + rand_bits(3))});
		irq_start = irq_pulses;
		run_command(`SMPC_CMD_INTBACK);
		check_byte("mirq_n pulses", 8'(irq_pulses - irq_start), 8'd1);
		for (int i = 0; i < 12; i++) begin
			host_read(oreg_addr(i), st[i]);
		end
		got = {st[1], st[2], st[3], st[4], st[5], st[6], st[7]};
		if (got == hi) lo = hi;
		want[0] = {1'b1, exp_resd, 6'b000000}; // STE from the earlier SETTIME
		want[1] = lo.year[15:8];
		want[2] = lo.year[7:0];
		want[3] = {lo.weekday, lo.month};
		want[4] = lo.days;
		want[5] = lo.hour;
		want[6] = lo.min;
		want[7] = lo.sec;
		want[8] = 8'h00;
		want[9] = {4'h0, area};
		want[10] = {3'b001, exp_resets.sshres_n, exp_resets.mshnmi_n, 1'b1,
			exp_resets.sysres_n, exp_resets.sndres_n};
		want[11] = {1'b0, exp_resets.cdres_n, 6'b000010};
		for (int i = 0; i < 12; i++) begin
			check_byte($sformatf("OREG%0d", i), st[i], want[i]);
		end
		host_read(`SMPC_A_SR, rd);
		check_byte("SR", rd, 8'h4F);
	endtask

	initial begin
		RST_N  = 1'b0;
		ce     = 1'b0;
		mres_n = 1'b1;
		addr   = '0;
		din    = '0;
		cs_n   = 1'b1;
		rw_n   = 1'b1;
		area   = 4'(rand_bits(4));
		repeat (3) @(posedge CLK);
		RST_N <= 1'b1;
		@(negedge CLK);
		exp_resets = '0;
		check_resets(resets, exp_resets);
		check_byte("mirq_n", {7'b0, mirq_n}, 8'h01);
		host_read(`SMPC_A_SF, rd);
		check_byte("SF", rd, 8'h00);
		host_read(`SMPC_A_SR, rd);
		check_byte("SR", rd, 8'h00);

		pulse_mres();
		exp_resets = '{mshres_n: 1'b1, mshnmi_n: 1'b1, sshres_n: 1'b0, sshnmi_n: 1'b1,
			sndres_n: 1'b0, cdres_n: 1'b1, sysres_n: 1'b1};
		exp_resd = 1'b1;
		check_resets(resets, exp_resets);

		repeat (24) begin
			code = line_cmds[rand_bits(3)];
			apply_line_command(code);
			run_command(code);
		end

		repeat (8) begin
			wdata = rand_bits(8);
			host_write(`SMPC_A_IREG0 + 6'(rand_bits(3) % 7), wdata);
			host_read(6'h3A, rd); // Unmapped address
			check_byte("echo", rd, wdata);
			host_read(`SMPC_A_SF, rd);
			check_byte("SF echo", rd, {wdata[7:1], 1'b0});
		end
		wdata = rand_bits(8);
		host_write(`SMPC_A_SF, wdata);
		host_read(`SMPC_A_SF, rd);
		check_byte("SF echo", rd, {wdata[7:1], 1'b1});

		repeat (3) begin
			set_time = random_time();
			load_time(set_time);
			ce_mark = ce_seen;
			code = rand_bits(1) ? `SMPC_CMD_RESENAB : `SMPC_CMD_RESDISA;
			apply_line_command(code);
			run_command(code);
			check_intback(set_time, ce_mark);
		end

		set_time = '{year: 16'h2023, weekday: 4'd2, month: 4'd2, days: 8'h28,
			hour: 8'h23, min: 8'h59, sec: 8'h59};
		load_time(set_time);
		ce_mark = ce_seen;
		wait_ce_count(`SMPC_RTC_TICK + 100);
		check_intback(set_time, ce_mark);

		repeat (4) begin
			code = 8'h20 | 8'(rand_bits(8));
			run_command(code);
		end
		host_write(`SMPC_A_IREG0, {4'(rand_bits(4)), 4'h0});
		run_command(`SMPC_CMD_INTBACK);

		$display("Run complete: %0d errors, %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- tb/smpc_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module smpc_assertions (
	input logic               CLK,
	input logic               RST_N,
	input logic [2:0]         state,
	input smpc_pkg::oreg_wr_t oreg_wr,
	input logic               sf_clear
);

	localparam logic [2:0] IDLE = 3'd0; // First entry of the sequencer state enum

	idle_no_oreg_write: assert property (
		@(posedge CLK) disable iff (!RST_N) (state == IDLE) |-> !oreg_wr.we
	) else $error("OREG write strobe while the sequencer is idle");

	sf_clear_single: assert property (
		@(posedge CLK) disable iff (!RST_N) sf_clear |=> !sf_clear
	) else $error("sf_clear held for more than one cycle");

	state_known: assert property (
		@(posedge CLK) disable iff (!RST_N) !$isunknown(state)
	) else $error("Sequencer state register holds an unknown value");

endmodule

`default_nettype wire

//--- hdl/smpc_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "smpc_defines.svh"

module smpc_top (
	input  logic                   CLK,
	input  logic                   RST_N,
	input  logic                   ce,
	input  logic                   mres_n,
	input  logic [5:0]             addr,
	input  smpc_pkg::smpc_byte_t   din,
	input  logic                   cs_n,
	input  logic                   rw_n,
	input  logic [3:0]             area,
	output smpc_pkg::smpc_byte_t   dout,
	output smpc_pkg::reset_lines_t resets,
	output logic                   mirq_n
);

	import smpc_pkg::*;

	smpc_byte_t ireg [`SMPC_IREG_COUNT];
	smpc_cmd_e  cmd_code;
	logic       cmd_pending;
	logic       cmd_taken;
	logic       sf_clear;
	smpc_byte_t sr;
	logic       sr_load;
	smpc_byte_t oreg_q;
	logic [4:0] oreg_raddr;
	oreg_wr_t   oreg_wr;
	logic       settime_load;
	rtc_time_t  now;

	smpc_host_regs host_regs_i (
		.CLK(CLK), .RST_N(RST_N), .ce(ce), .addr(addr), .din(din), .cs_n(cs_n), .rw_n(rw_n),
		.cmd_taken(cmd_taken), .sf_clear(sf_clear), .sr(sr), .sr_load(sr_load),
		.oreg_q(oreg_q), .dout(dout), .ireg(ireg), .cmd_code(cmd_code),
		.cmd_pending(cmd_pending), .oreg_raddr(oreg_raddr)
	);

	smpc_command command_i (
		.CLK(CLK), .RST_N(RST_N), .ce(ce), .mres_n(mres_n), .cmd_code(cmd_code),
		.cmd_pending(cmd_pending), .ireg(ireg), .now(now), .area(area),
		.cmd_taken(cmd_taken), .sf_clear(sf_clear), .sr(sr), .sr_load(sr_load),
		.oreg_wr(oreg_wr), .settime_load(settime_load), .resets(resets), .mirq_n(mirq_n)
	);

	smpc_rtc rtc_i (
		.CLK(CLK), .RST_N(RST_N), .ce(ce), .settime_load(settime_load), .ireg(ireg), .now(now)
	);

	smpc_oreg_ram oreg_ram_i (
		.CLK(CLK), .oreg_wr(oreg_wr), .oreg_raddr(oreg_raddr), .oreg_q(oreg_q)
	);

endmodule

`default_nettype wire

//--- hdl/smpc_command.sv
`timescale 1ns/1ps
`default_nettype none

`include "smpc_defines.svh"

module smpc_command (
	input  logic                   CLK,
	input  logic                   RST_N,
	input  logic                   ce,
	input  logic                   mres_n,
	input  smpc_pkg::smpc_cmd_e    cmd_code,
	input  logic                   cmd_pending,
	input  smpc_pkg::smpc_byte_t   ireg [`SMPC_IREG_COUNT],
	input  smpc_pkg::rtc_time_t    now,
	input  logic [3:0]             area,
	output logic                   cmd_taken,
	output logic                   sf_clear,
	output smpc_pkg::smpc_byte_t   sr,
	output logic                   sr_load,
	output smpc_pkg::oreg_wr_t     oreg_wr,
	output logic                   settime_load,
	output smpc_pkg::reset_lines_t resets,
	output logic                   mirq_n
);

	import smpc_pkg::*;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_ACCEPT,
		ST_WRCODE,
		ST_EXEC_WAIT,
		ST_EXECUTE,
		ST_STATUS,
		ST_END
	} state_e;

	state_e     state;
	logic [5:0] cnt;
	logic [3:0] idx; // Next INTBACK status byte
	smpc_cmd_e  cmd;
	rtc_time_t  snap;
	logic       resd;
	logic       ste;
	logic       taken_q;
	logic       sf_clear_q;
	logic       sr_load_q;
	logic       settime_q;
	oreg_wr_t   wr_q;
	smpc_byte_t status_byte;

	// Strobes last one clock, in the ce cycle that consumes them
	assign cmd_taken    = taken_q & ce;
	assign sf_clear     = sf_clear_q & ce;
	assign sr_load      = sr_load_q & ce;
	assign settime_load = settime_q & ce;
	assign oreg_wr      = '{we: wr_q.we & ce, addr: wr_q.addr, data: wr_q.data};

	always_comb begin
		case (idx)
			4'd0:    status_byte = {ste, resd, 6'b000000};
			4'd1:    status_byte = snap.year[15:8];
			4'd2:    status_byte = snap.year[7:0];
			4'd3:    status_byte = {snap.weekday, snap.month};
			4'd4:    status_byte = snap.days;
			4'd5:    status_byte = snap.hour;
			4'd6:    status_byte = snap.min;
			4'd7:    status_byte = snap.sec;
			4'd8:    status_byte = 8'h00;
			4'd9:    status_byte = {4'b0000, area};
			4'd10:   status_byte = {2'b00, 1'b1, resets.sshres_n, resets.mshnmi_n, 1'b1,
				resets.sysres_n, resets.sndres_n};
			default: status_byte = {1'b0, resets.cdres_n, 6'b000010};
		endcase
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			state      <= ST_IDLE;
			cnt        <= '0;
			idx        <= '0;
			resets     <= '0;
			resd       <= 1'b1;
			ste        <= 1'b0;
			sr         <= '0;
			mirq_n     <= 1'b1;
			taken_q    <= 1'b0;
			sf_clear_q <= 1'b0;
			sr_load_q  <= 1'b0;
			settime_q  <= 1'b0;
			wr_q       <= '0;
		end else if (ce) begin
			taken_q    <= 1'b0;
			sf_clear_q <= 1'b0;
			sr_load_q  <= 1'b0;
			settime_q  <= 1'b0;
			wr_q.we    <= 1'b0;
			mirq_n     <= 1'b1;
			if (!mres_n) begin
				resets <= '{mshres_n: 1'b1, mshnmi_n: 1'b1, sshres_n: 1'b0, sshnmi_n: 1'b1,
					sndres_n: 1'b0, cdres_n: 1'b1, sysres_n: 1'b1};
				resd      <= 1'b1;
				sr        <= '0;
				sr_load_q <= 1'b1;
				state     <= ST_IDLE;
			end else begin
				case (state)
					ST_IDLE: if (cmd_pending) begin
						taken_q <= 1'b1;
						cnt     <= 6'(`SMPC_WAIT_ACCEPT - 1);
						state   <= ST_ACCEPT;
					end
					ST_ACCEPT: if (cnt == '0) state <= ST_WRCODE; else cnt <= cnt - 6'd1;
					ST_WRCODE: begin
						wr_q <= '{we: 1'b1, addr: 5'(`SMPC_OREG_CMD_INDEX), data: cmd};
						if (cmd >= 8'h20 || (cmd == CMD_INTBACK && ireg[0][3:0] == 4'h0)) begin
							state <= ST_END; // No effect
						end else begin
							cnt   <= 6'(`SMPC_WAIT_EXEC - 1);
							state <= ST_EXEC_WAIT;
						end
					end
					ST_EXEC_WAIT: if (cnt == '0) state <= ST_EXECUTE; else cnt <= cnt - 6'd1;
					ST_EXECUTE: begin
						state <= ST_END;
						case (cmd)
							CMD_MSHON:   {resets.mshres_n, resets.mshnmi_n} <= 2'b11;
							CMD_SSHON:   {resets.sshres_n, resets.sshnmi_n} <= 2'b11;
							CMD_SSHOFF:  {resets.sshres_n, resets.sshnmi_n} <= 2'b01;
							CMD_SNDON:   resets.sndres_n <= 1'b1;
							CMD_SNDOFF:  resets.sndres_n <= 1'b0;
							CMD_CDON:    resets.cdres_n <= 1'b1;
							CMD_CDOFF:   resets.cdres_n <= 1'b0;
							CMD_NMIREQ:  resets.mshnmi_n <= 1'b0; // Released in end
							CMD_RESENAB: resd <= 1'b0;
							CMD_RESDISA: resd <= 1'b1;
							CMD_SETTIME: begin
								ste       <= 1'b1;
								settime_q <= 1'b1;
							end
							CMD_INTBACK: begin
								idx   <= '0;
								cnt   <= 6'(`SMPC_WAIT_INTBACK_STEP - 1);
								state <= ST_STATUS;
							end
							default: ;
						endcase
					end
					ST_STATUS: begin
						if (cnt != '0) begin
							cnt <= cnt - 6'd1;
						end else begin
							wr_q <= '{we: 1'b1, addr: {1'b0, idx}, data: status_byte};
							idx  <= idx + 4'd1;
							cnt  <= 6'(`SMPC_WAIT_INTBACK_STEP - 1);
							if (idx == 4'd11) begin
								sr        <= 8'h4F;
								sr_load_q <= 1'b1;
								mirq_n    <= 1'b0;
								state     <= ST_END;
							end
						end
					end
					ST_END: begin
						sf_clear_q <= 1'b1;
						if (cmd == CMD_NMIREQ) resets.mshnmi_n <= 1'b1;
						state <= ST_IDLE;
					end
					default: state <= ST_IDLE;
				endcase
			end
		end
	end

	// Time is frozen for the whole status dump
	always_ff @(posedge CLK) begin
		if (ce && mres_n) begin
			if (state == ST_IDLE && cmd_pending) cmd <= cmd_code;
			if (state == ST_EXECUTE) snap <= now;
		end
	end

endmodule

`default_nettype wire

//--- hdl/smpc_rtc.sv
`timescale 1ns/1ps
`default_nettype none

`include "smpc_defines.svh"

module smpc_rtc (
	input  logic                 CLK,
	input  logic                 RST_N,
	input  logic                 ce,
	input  logic                 settime_load,
	input  smpc_pkg::smpc_byte_t ireg [`SMPC_IREG_COUNT],
	output smpc_pkg::rtc_time_t  now
);

	import smpc_pkg::*;

	logic [15:0] div;
	logic        tick;
	logic        sec_end;
	logic        min_end;
	logic        hour_end;
	logic        day_end;
	logic        mon_end;
	logic        yr_lo_end;

	function automatic smpc_byte_t bcd_inc(input smpc_byte_t v);
		if (v == 8'h99) return 8'h00;
		if (v[3:0] == 4'd9) return {v[7:4] + 4'd1, 4'd0};
		return {v[7:4], v[3:0] + 4'd1};
	endfunction

	assign tick      = (div == 16'(`SMPC_RTC_TICK - 1));
	assign sec_end   = (now.sec == 8'h59);
	assign min_end   = (now.min == 8'h59);
	assign hour_end  = (now.hour == 8'h23);
	assign mon_end   = (now.month == 4'd12);
	assign yr_lo_end = (now.year[7:0] == 8'h99);

	// No leap years
	always_comb begin
		case (now.month)
			4'd2:                    day_end = (now.days == 8'h28);
			4'd4, 4'd6, 4'd9, 4'd11: day_end = (now.days == 8'h30);
			default:                 day_end = (now.days == 8'h31);
		endcase
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			div <= '0;
			now <= '{year: 16'h2024, weekday: 4'd1, month: 4'd1, days: 8'h01,
				hour: 8'h00, min: 8'h00, sec: 8'h00};
		end else if (ce) begin
			if (settime_load) begin
				div <= '0;
				now <= '{year: {ireg[0], ireg[1]}, weekday: ireg[2][7:4], month: ireg[2][3:0],
					days: ireg[3], hour: ireg[4], min: ireg[5], sec: ireg[6]};
			end else begin
				div <= tick ? '0 : div + 16'd1;
				if (tick) begin
					now.sec <= sec_end ? 8'h00 : bcd_inc(now.sec);
					if (sec_end) begin
						now.min <= min_end ? 8'h00 : bcd_inc(now.min);
						if (min_end) begin
							now.hour <= hour_end ? 8'h00 : bcd_inc(now.hour);
							if (hour_end) begin
								now.days <= day_end ? 8'h01 : bcd_inc(now.days); // Weekday held
								if (day_end) begin
									now.month <= mon_end ? 4'd1 : now.month + 4'd1;
									if (mon_end) begin
										now.year[7:0] <= bcd_inc(now.year[7:0]);
										if (yr_lo_end) begin
											now.year[15:8] <= bcd_inc(now.year[15:8]);
										end
									end
								end
							end
						end
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- hdl/smpc_host_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "smpc_defines.svh"

module smpc_host_regs (
	input  logic                 CLK,
	input  logic                 RST_N,
	input  logic                 ce,
	input  logic [5:0]           addr,
	input  smpc_pkg::smpc_byte_t din,
	input  logic                 cs_n,
	input  logic                 rw_n,
	input  logic                 cmd_taken,
	input  logic                 sf_clear,
	input  smpc_pkg::smpc_byte_t sr,
	input  logic                 sr_load,
	input  smpc_pkg::smpc_byte_t oreg_q,
	output smpc_pkg::smpc_byte_t dout,
	output smpc_pkg::smpc_byte_t ireg [`SMPC_IREG_COUNT],
	output smpc_pkg::smpc_cmd_e  cmd_code,
	output logic                 cmd_pending,
	output logic [4:0]           oreg_raddr
);

	import smpc_pkg::*;

	logic       rw_n_q;
	logic       cs_n_q;
	logic       wr_edge;
	logic       rd_edge;
	host_wr_t   wr_q; // Data field doubles as the echo byte
	logic [5:0] ireg_off;
	smpc_byte_t sr_q;
	logic       sf;
	smpc_byte_t rd_data;

	assign wr_edge    = rw_n_q & ~rw_n & ~cs_n;
	assign rd_edge    = cs_n_q & ~cs_n & rw_n;
	assign ireg_off   = wr_q.addr - `SMPC_A_IREG0;
	assign oreg_raddr = 5'(addr - `SMPC_A_OREG_FIRST);

	always_comb begin
		if (addr >= `SMPC_A_OREG_FIRST && addr <= `SMPC_A_OREG_LAST) begin
			rd_data = oreg_q;
		end else if (addr == `SMPC_A_SR) begin
			rd_data = sr_q;
		end else if (addr == `SMPC_A_SF) begin
			rd_data = {wr_q.data[7:1], sf};
		end else begin
			rd_data = wr_q.data;
		end
	end

	// Bus side runs every clock, the write is applied on the next ce
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			rw_n_q <= 1'b1;
			cs_n_q <= 1'b1;
			wr_q   <= '0;
			dout   <= '0;
		end else begin
			rw_n_q <= rw_n;
			cs_n_q <= cs_n;
			if (wr_edge) begin
				wr_q <= '{strobe: 1'b1, addr: addr, data: din};
			end else if (ce) begin
				wr_q.strobe <= 1'b0;
			end
			if (rd_edge) begin
				dout <= rd_data;
			end
		end
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			cmd_pending <= 1'b0;
			sf          <= 1'b0;
			sr_q        <= '0;
		end else if (ce) begin
			if (cmd_taken) cmd_pending <= 1'b0;
			if (sf_clear) sf <= 1'b0;
			if (sr_load) sr_q <= sr;
			if (wr_q.strobe && wr_q.addr == `SMPC_A_COMREG) cmd_pending <= 1'b1;
			if (wr_q.strobe && wr_q.addr == `SMPC_A_SF) sf <= 1'b1;
		end
	end

	always_ff @(posedge CLK) begin
		if (ce && wr_q.strobe) begin
			if (ireg_off < 6'(`SMPC_IREG_COUNT)) begin
				ireg[ireg_off[2:0]] <= wr_q.data;
			end
			if (wr_q.addr == `SMPC_A_COMREG) begin
				cmd_code <= smpc_cmd_e'(wr_q.data); // Later write overwrites a pending code
			end
		end
	end

endmodule

`default_nettype wire

//--- hdl/smpc_oreg_ram.sv
`timescale 1ns/1ps
`default_nettype none

module smpc_oreg_ram (
	input  logic                 CLK,
	input  smpc_pkg::oreg_wr_t   oreg_wr,
	input  logic [4:0]           oreg_raddr,
	output smpc_pkg::smpc_byte_t oreg_q
);

	import smpc_pkg::*;

	smpc_byte_t mem [32];

	always_ff @(posedge CLK) begin
		if (oreg_wr.we) begin
			mem[oreg_wr.addr] <= oreg_wr.data;
		end
	end

	// Host read path is combinational, dout registers it
	assign oreg_q = mem[oreg_raddr];

endmodule

`default_nettype wire

//--- hdl/smpc_pkg.sv
`default_nettype none

`include "smpc_defines.svh"

package smpc_pkg;

	typedef logic [7:0] smpc_byte_t;

	typedef struct packed {
		logic       strobe;
		logic [5:0] addr;
		smpc_byte_t data;
	} host_wr_t;

	typedef struct packed {
		logic mshres_n;
		logic mshnmi_n;
		logic sshres_n;
		logic sshnmi_n;
		logic sndres_n;
		logic cdres_n;
		logic sysres_n;
	} reset_lines_t;

	typedef struct packed {
		logic [15:0] year;
		logic [3:0]  weekday;
		logic [3:0]  month; // Binary 1..12
		smpc_byte_t  days;
		smpc_byte_t  hour;
		smpc_byte_t  min;
		smpc_byte_t  sec;
	} rtc_time_t;

	typedef struct packed {
		logic       we;
		logic [4:0] addr;
		smpc_byte_t data;
	} oreg_wr_t;

	typedef enum logic [7:0] {
		CMD_MSHON   = `SMPC_CMD_MSHON,
		CMD_SSHON   = `SMPC_CMD_SSHON,
		CMD_SSHOFF  = `SMPC_CMD_SSHOFF,
		CMD_SNDON   = `SMPC_CMD_SNDON,
		CMD_SNDOFF  = `SMPC_CMD_SNDOFF,
		CMD_CDON    = `SMPC_CMD_CDON,
		CMD_CDOFF   = `SMPC_CMD_CDOFF,
		CMD_INTBACK = `SMPC_CMD_INTBACK,
		CMD_SETTIME = `SMPC_CMD_SETTIME,
		CMD_NMIREQ  = `SMPC_CMD_NMIREQ,
		CMD_RESENAB = `SMPC_CMD_RESENAB,
		CMD_RESDISA = `SMPC_CMD_RESDISA
	} smpc_cmd_e;

endpackage

`default_nettype wire

//--- include/smpc_defines.svh
`ifndef SMPC_DEFINES_SVH
`define SMPC_DEFINES_SVH

// Host register addresses as seen on A6..A1
`define SMPC_A_IREG0        6'h00
`define SMPC_A_COMREG       6'h0F
`define SMPC_A_OREG_FIRST   6'h10
`define SMPC_A_OREG_LAST    6'h2F
`define SMPC_A_SR           6'h30
`define SMPC_A_SF           6'h31

`define SMPC_CMD_MSHON      8'h00
`define SMPC_CMD_SSHON      8'h02
`define SMPC_CMD_SSHOFF     8'h03
`define SMPC_CMD_SNDON      8'h06
`define SMPC_CMD_SNDOFF     8'h07
`define SMPC_CMD_CDON       8'h08
`define SMPC_CMD_CDOFF      8'h09
`define SMPC_CMD_INTBACK    8'h10
`define SMPC_CMD_SETTIME    8'h16
`define SMPC_CMD_NMIREQ     8'h18
`define SMPC_CMD_RESENAB    8'h19
`define SMPC_CMD_RESDISA    8'h1A

// Sequencer waits, all in ce cycles
`define SMPC_WAIT_ACCEPT        20
`define SMPC_WAIT_EXEC          16
`define SMPC_WAIT_INTBACK_STEP  4 // Spacing of INTBACK status bytes

`define SMPC_RTC_TICK       2048 // ce cycles per RTC second
`define SMPC_IREG_COUNT     7
`define SMPC_OREG_CMD_INDEX 31

`endif
